// ==== bellmanFord.sv ====
`timescale 1ns/1ps
`default_nettype none

module bellmanFord
(
    input wire clock,
    input wire reset,
    input wire start,
    input wire bfPkg::nodeT sourceNode,
    input wire bfPkg::nodeT numNodes,
    input wire bfPkg::edgeCountT numEdges,
    output bfPkg::edgeAddrT edgeAddr,
    input wire bfPkg::edgeT edgeData,
    output logic done,
    output logic negCycle,
    input wire bfPkg::nodeT resultNode,
    output bfPkg::distT resultDist
);

    // Fetcher to FIFO
    logic fetchValid;
    logic fetchReady;
    bfPkg::edgeT fetchEdge;
    logic fetchLast;

    // FIFO to relaxer
    logic relaxValid;
    logic relaxReady;
    bfPkg::edgeT relaxEdge;
    logic relaxLast;

    logic initTable;
    logic passStart;
    logic passDone;
    logic passUpdated;

    edgeFetcher fetcher
    (
        .clock(clock),
        .reset(reset),
        .passStart(passStart),
        .numEdges(numEdges),
        .edgeAddr(edgeAddr),
        .edgeData(edgeData),
        .outValid(fetchValid),
        .outReady(fetchReady),
        .outEdge(fetchEdge),
        .outLast(fetchLast)
    );

    edgeFifo fifo
    (
        .clock(clock),
        .reset(reset),
        .inValid(fetchValid),
        .inReady(fetchReady),
        .inEdge(fetchEdge),
        .inLast(fetchLast),
        .outValid(relaxValid),
        .outReady(relaxReady),
        .outEdge(relaxEdge),
        .outLast(relaxLast)
    );

    relaxUnit relaxer
    (
        .clock(clock),
        .reset(reset),
        .initTable(initTable),
        .sourceNode(sourceNode),
        .inValid(relaxValid),
        .inReady(relaxReady),
        .inEdge(relaxEdge),
        .inLast(relaxLast),
        .passDone(passDone),
        .passUpdated(passUpdated),
        .resultNode(resultNode),
        .resultDist(resultDist)
    );

    passController control
    (
        .clock(clock),
        .reset(reset),
        .start(start),
        .numNodes(numNodes),
        .passDone(passDone),
        .passUpdated(passUpdated),
        .initTable(initTable),
        .passStart(passStart),
        .done(done),
        .negCycle(negCycle)
    );

endmodule

`default_nettype wire

// ==== bfDefines.svh ====
`ifndef BF_DEFINES_SVH
`define BF_DEFINES_SVH

// Graph size limits
`define BF_MAX_NODES 16
`define BF_NODE_W 4
`define BF_MAX_EDGES 64
`define BF_EDGE_ADDR_W 6

// Signed weight per edge
`define BF_WEIGHT_W 8

// Distance is wider than a weight so that 15 summed weights cannot overflow
`define BF_DIST_W 12

`define BF_FIFO_DEPTH 4 // Power of two

`endif

// ==== bfPkg.sv ====
`default_nettype none

`include "bfDefines.svh"

package bfPkg;

    typedef logic [`BF_NODE_W-1:0] nodeT;

    typedef logic signed [`BF_WEIGHT_W-1:0] weightT;

    typedef logic [`BF_EDGE_ADDR_W-1:0] edgeAddrT;

    // Holds 0 to BF_MAX_EDGES inclusive
    typedef logic [`BF_EDGE_ADDR_W:0] edgeCountT;

    typedef struct packed {
        logic inf; // Node not reached yet
        logic signed [`BF_DIST_W-1:0] value;
    } distT;

    // One edge memory word
    typedef struct packed {
        nodeT src;
        nodeT dst;
        weightT weight;
    } edgeT;

endpackage

`default_nettype wire

// ==== edgeFetcher.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bfDefines.svh"

module edgeFetcher
(
    input wire clock,
    input wire reset,
    input wire passStart,
    input wire bfPkg::edgeCountT numEdges,
    output bfPkg::edgeAddrT edgeAddr,
    input wire bfPkg::edgeT edgeData,
    output logic outValid,
    input wire outReady,
    output bfPkg::edgeT outEdge,
    output logic outLast
);

    bfPkg::edgeAddrT addrReg;
    bfPkg::edgeAddrT lastAddr;
    logic active;
    logic issue;
    logic emptyPass;
    logic reqValid; // edgeData answers last cycle's address
    logic reqLast;
    logic holdValid;
    logic holdLast;
    bfPkg::edgeT holdEdge;

    assign lastAddr = bfPkg::edgeAddrT'(numEdges - 1'b1);
    assign emptyPass = passStart & (numEdges == '0);
    assign edgeAddr = addrReg;

    // Held word goes first, the word in flight waits behind it
    assign outValid = holdValid | reqValid;
    assign outEdge = holdValid ? holdEdge : edgeData;
    assign outLast = holdValid ? holdLast : reqLast;

    // Next address only when the word now arriving has somewhere to go
    assign issue = active & (holdValid ? outReady : (outReady | ~reqValid));

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            active <= 1'b0;
            addrReg <= '0;
            reqValid <= 1'b0;
            holdValid <= 1'b0;
        end
        else
        begin
            reqValid <= issue;
            if (passStart)
            begin
                addrReg <= '0;
                active <= (numEdges != '0);
            end
            else if (issue)
            begin
                addrReg <= addrReg + 1'b1;
                if (addrReg == lastAddr)
                    active <= 1'b0; // Final address of the pass sent
            end

            if (emptyPass)
                holdValid <= 1'b1;
            else if (holdValid && outReady)
                holdValid <= 1'b0;
            else if (reqValid && !outReady)
                holdValid <= 1'b1;
        end
    end

    always_ff @(posedge clock)
    begin
        reqLast <= issue & (addrReg == lastAddr);
        // A pass without edges sends a zero-weight self-loop on node 0, which never relaxes
        if (emptyPass)
        begin
            holdEdge <= '0;
            holdLast <= 1'b1;
        end
        else if (!holdValid && reqValid && !outReady)
        begin
            holdEdge <= edgeData;
            holdLast <= reqLast;
        end
    end

endmodule

`default_nettype wire

// ==== edgeFifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bfDefines.svh"

module edgeFifo
#(
    parameter int depth = `BF_FIFO_DEPTH
)
(
    input wire clock,
    input wire reset,
    input wire inValid,
    output logic inReady,
    input wire bfPkg::edgeT inEdge,
    input wire inLast,
    output logic outValid,
    input wire outReady,
    output bfPkg::edgeT outEdge,
    output logic outLast
);

    localparam int ptrW = $clog2(depth);

    bfPkg::edgeT edgeMem [depth];
    logic lastMem [depth];
    logic [ptrW-1:0] wrPtr;
    logic [ptrW-1:0] rdPtr;
    logic [ptrW:0] count;
    logic push;
    logic pop;

    // Count reaches depth only with its top bit set
    assign inReady = ~count[ptrW];
    assign outValid = (count != '0);
    assign push = inValid & inReady;
    assign pop = outValid & outReady;

    assign outEdge = edgeMem[rdPtr];
    assign outLast = lastMem[rdPtr];

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else
        begin
            if (push)
                wrPtr <= wrPtr + 1'b1; // Wraps because depth is a power of two
            if (pop)
                rdPtr <= rdPtr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clock)
    begin
        if (push)
        begin
            edgeMem[wrPtr] <= inEdge;
            lastMem[wrPtr] <= inLast;
        end
    end

endmodule

`default_nettype wire

// ==== passController.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bfDefines.svh"

module passController
(
    input wire clock,
    input wire reset,
    input wire start,
    input wire bfPkg::nodeT numNodes,
    input wire passDone,
    input wire passUpdated,
    output logic initTable,
    output logic passStart,
    output logic done,
    output logic negCycle
);

    typedef enum logic [1:0] {idle, init, running, finished} stateT;

    stateT state;
    bfPkg::nodeT passCount; // Passes completed in this run
    logic checkPass;

    // Pass numNodes is the extra one that looks for a negative cycle
    assign checkPass = ({1'b0, passCount} + 1'b1) >= {1'b0, numNodes};

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state <= idle;
            initTable <= 1'b0;
            passStart <= 1'b0;
            done <= 1'b0;
            negCycle <= 1'b0;
            passCount <= '0;
        end
        else
        begin
            initTable <= 1'b0;
            passStart <= 1'b0;
            case (state)
                idle, finished:
                    if (start)
                    begin
                        state <= init;
                        initTable <= 1'b1;
                        done <= 1'b0;
                        negCycle <= 1'b0;
                        passCount <= '0;
                    end
                init:
                begin
                    state <= running;
                    passStart <= 1'b1;
                end
                running:
                    if (passDone)
                    begin
                        passCount <= passCount + 1'b1;
                        if (!passUpdated || checkPass)
                        begin
                            state <= finished;
                            done <= 1'b1;
                            negCycle <= passUpdated; // Still improving after numNodes-1 passes
                        end
                        else
                            passStart <= 1'b1;
                    end
                default:
                    state <= idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== relaxUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bfDefines.svh"

module relaxUnit
(
    input wire clock,
    input wire reset,
    input wire initTable,
    input wire bfPkg::nodeT sourceNode,
    input wire inValid,
    output logic inReady,
    input wire bfPkg::edgeT inEdge,
    input wire inLast,
    output logic passDone,
    output logic passUpdated,
    input wire bfPkg::nodeT resultNode,
    output bfPkg::distT resultDist
);

    bfPkg::distT distTable [`BF_MAX_NODES];
    bfPkg::distT srcDist;
    bfPkg::distT dstDist;
    logic signed [`BF_DIST_W-1:0] newValue;
    logic take;
    logic relax;
    logic updatedSoFar;

    assign inReady = 1'b1; // Takes one edge every cycle
    assign take = inValid & inReady;

    assign srcDist = distTable[inEdge.src];
    assign dstDist = distTable[inEdge.dst];
    assign newValue = $signed(srcDist.value) + $signed(inEdge.weight);

    // Only a reached source can improve its neighbour
    assign relax = take & ~srcDist.inf
        & (dstDist.inf | (newValue < $signed(dstDist.value)));

    assign resultDist = distTable[resultNode];

    always_ff @(posedge clock)
    begin
        if (initTable)
        begin
            for (int i = 0; i < `BF_MAX_NODES; i++)
            begin
                distTable[i].inf <= (bfPkg::nodeT'(i) != sourceNode);
                distTable[i].value <= '0;
            end
        end
        else if (relax)
        begin
            distTable[inEdge.dst].inf <= 1'b0;
            distTable[inEdge.dst].value <= newValue;
        end
    end

    // Per-pass record of whether any distance moved
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            passDone <= 1'b0;
            passUpdated <= 1'b0;
            updatedSoFar <= 1'b0;
        end
        else
        begin
            passDone <= take & inLast;
            if (initTable)
                updatedSoFar <= 1'b0;
            else if (take && inLast)
            begin
                passUpdated <= updatedSoFar | relax;
                updatedSoFar <= 1'b0;
            end
            else if (take)
                updatedSoFar <= updatedSoFar | relax;
        end
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+.
bfPkg.sv
edgeFetcher.sv
edgeFifo.sv
relaxUnit.sv
passController.sv
bellmanFord.sv
tbBellmanFord.sv

// ==== tbGraphs.svh ====
`ifndef TB_GRAPHS_SVH
`define TB_GRAPHS_SVH

// Starts a new graph with no edges
task automatic newGraph(input int nodes, input int source);
    gNodes = nodes;
    gSource = source;
    gEdges = 0;
endtask

task automatic addEdge(input int src, input int dst, input int weight);
    gSrc[gEdges] = src;
    gDst[gEdges] = dst;
    gWeight[gEdges] = weight;
    gEdges++;
endtask

// Words past the edge list hold negative weights, so a fetch past the end shows up
task automatic loadEdgeMemory();
    for (int a = 0; a < `BF_MAX_EDGES; a++)
    begin
        if (a < gEdges)
            edgeMem[a] = {bfPkg::nodeT'(gSrc[a]), bfPkg::nodeT'(gDst[a]),
                bfPkg::weightT'(gWeight[a])};
        else
            edgeMem[a] = {bfPkg::nodeT'(a), bfPkg::nodeT'(a >> 2), bfPkg::weightT'(8'h80 | a)};
    end
endtask

// Edges relaxed in list order, numNodes-1 passes at most, then one check pass
task automatic computeExpected();
    int pass;
    bit changed;
    for (int i = 0; i < `BF_MAX_NODES; i++)
    begin
        expInf[i] = (i != gSource);
        expVal[i] = 0;
    end
    expNeg = 1'b0;
    pass = 0;
    changed = 1'b1;
    while (changed)
    begin
        pass++;
        changed = 1'b0;
        for (int e = 0; e < gEdges; e++)
        begin
            if (!expInf[gSrc[e]] && (expInf[gDst[e]]
                || expVal[gSrc[e]] + gWeight[e] < expVal[gDst[e]]))
            begin
                expInf[gDst[e]] = 1'b0;
                expVal[gDst[e]] = expVal[gSrc[e]] + gWeight[e];
                changed = 1'b1;
            end
        end
        if (changed && pass >= gNodes)
        begin
            expNeg = 1'b1; // Still relaxing in the check pass
            changed = 1'b0;
        end
    end
endtask

// Small weights keep every distance well inside the signed range
task automatic randomGraph();
    int nodes;
    int edges;
    nodes = 2 + int'({$random(seed)} % 9);
    edges = int'({$random(seed)} % 25);
    newGraph(nodes, int'({$random(seed)} % nodes));
    for (int e = 0; e < edges; e++)
        addEdge(int'({$random(seed)} % nodes), int'({$random(seed)} % nodes),
            int'({$random(seed)} % 33) - 3);
endtask

`endif

// ==== tbBellmanFord.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bfDefines.svh"

module tbBellmanFord;

    logic clock;
    logic reset;
    logic start;
    bfPkg::nodeT sourceNode;
    bfPkg::nodeT numNodes;
    bfPkg::edgeCountT numEdges;
    bfPkg::edgeAddrT edgeAddr;
    bfPkg::edgeT edgeData;
    logic done;
    logic negCycle;
    bfPkg::nodeT resultNode;
    bfPkg::distT resultDist;

    bfPkg::edgeT edgeMem [`BF_MAX_EDGES];

    // Graph under test and the model's answer
    int gNodes;
    int gSource;
    int gEdges;
    int gSrc [`BF_MAX_EDGES];
    int gDst [`BF_MAX_EDGES];
    int gWeight [`BF_MAX_EDGES];
    bit expInf [`BF_MAX_NODES];
    int expVal [`BF_MAX_NODES];
    bit expNeg;

    integer seed;
    int errors;
    int checks;
    int budget = 40; // Cycle allowance that grows with each run
    int cycles = 0;

    `include "tbGraphs.svh"

    bellmanFord UUT (.*);

    initial
    begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    always @(posedge clock)
        edgeData <= edgeMem[edgeAddr]; // One-cycle synchronous read

    initial
    begin
        while (cycles <= budget)
        begin
            @(posedge clock);
            cycles++;
        end
        $display("Watchdog expired after %0d cycles, a run never reached done", cycles);
        $display("=== FAIL ===");
        $finish;
    end

    // Loads the graph, runs the engine and compares the whole table with the model
    task automatic runAndCheck(input string name);
        loadEdgeMemory();
        computeExpected();
        budget += (gNodes + 1) * (gEdges + 8) + 50;
        @(negedge clock);
        sourceNode = bfPkg::nodeT'(gSource);
        numNodes = bfPkg::nodeT'(gNodes);
        numEdges = bfPkg::edgeCountT'(gEdges);
        start = 1'b1;
        @(negedge clock);
        start = 1'b0;
        while (!done)
            @(negedge clock);
        checks++;
        assert (negCycle == expNeg)
        else
        begin
            $display("[FAIL] %0t %s negCycle got %0b expected %0b", $time, name, negCycle, expNeg);
            errors++;
        end
        for (int i = 0; i < `BF_MAX_NODES; i++)
        begin
            @(negedge clock);
            resultNode = bfPkg::nodeT'(i);
            #1;
            checks++;
            assert (resultDist.inf == expInf[i] && (expInf[i] || resultDist.value == expVal[i]))
            else
            begin
                $display("[FAIL] %0t %s resultDist[%0d] got inf=%0b %0d expected inf=%0b %0d",
                    $time, name, i, resultDist.inf, resultDist.value, expInf[i], expVal[i]);
                errors++;
            end
        end
    endtask

    initial
    begin
        reset = 1'b1;
        start = 1'b0;
        sourceNode = '0;
        numNodes = '0;
        numEdges = '0;
        resultNode = '0;
        edgeData = '0;
        seed = 32'h85a8_0a64;
        errors = 0;
        checks = 0;
        newGraph(1, 0);
        loadEdgeMemory();
        repeat (10) @(negedge clock);
        reset = 1'b0;

        newGraph(6, 0);
        addEdge(0, 1, 4);
        addEdge(0, 2, 1);
        addEdge(2, 1, 2);
        addEdge(1, 3, 5);
        addEdge(2, 3, 8);
        addEdge(3, 4, 3);
        addEdge(4, 5, 1);
        addEdge(2, 5, 20);
        runAndCheck("positive");

        // Chain listed backwards needs one pass per hop
        newGraph(8, 0);
        for (int i = 6; i >= 0; i--)
            addEdge(i, i + 1, (i % 2) ? -4 : 3);
        addEdge(0, 7, 40);
        runAndCheck("reverse chain");

        newGraph(7, 3);
        addEdge(3, 4, 2);
        addEdge(4, 5, -1);
        addEdge(1, 2, 6);
        addEdge(2, 1, 3);
        addEdge(5, 6, 4);
        addEdge(0, 3, 1);
        runAndCheck("unreachable");

        newGraph(5, 0);
        addEdge(0, 1, 2);
        addEdge(1, 2, -3);
        addEdge(2, 3, 1);
        addEdge(3, 1, -1); // Cycle 1 2 3 sums to -3
        addEdge(3, 4, 2);
        runAndCheck("negative cycle");

        newGraph(6, 0);
        addEdge(0, 1, 3);
        addEdge(1, 2, 4);
        addEdge(3, 4, -5);
        addEdge(4, 5, 1);
        addEdge(5, 3, 2);
        runAndCheck("isolated negative cycle");

        repeat (20)
        begin
            randomGraph();
            runAndCheck("random");
        end

        newGraph(1, 0);
        addEdge(0, 0, 5);
        runAndCheck("single node");
        newGraph(5, 2);
        runAndCheck("no edges");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire
